// ==== source/alu_pkg.sv ====
// ALU package
//   data width and shift-amount width
//   operation encoding (selector order add/sub, sll, slt, sltu, xor, sr, or, and)
//   flag struct and registered result struct
package alu_pkg;

  // datapath width
  localparam int xlen = 64;

  // shift amount covers 0 .. xlen-1
  localparam int shamt_w = $clog2(xlen);

  // low three bits pick the result source
  // bit 3 marks the alternate form (sub, arithmetic shift)
  typedef enum logic [3:0] {
    op_add  = 4'b0000,
    op_sll  = 4'b0001,
    op_slt  = 4'b0010,
    op_sltu = 4'b0011,
    op_xor  = 4'b0100,
    op_srl  = 4'b0101,
    op_or   = 4'b0110,
    op_and  = 4'b0111,
    op_sub  = 4'b1000,
    op_sra  = 4'b1101
  } alu_op_e;

  // flags always describe the adder output
  typedef struct packed {
    logic zero;
    logic negative;
    logic carry;
    logic overflow;
  } alu_flags_t;

  // what the execute stage presents one cycle later
  typedef struct packed {
    logic [xlen-1:0] result;
    logic            branch_taken;
  } exec_result_t;

endpackage

// ==== source/rv_isa_pkg.sv ====
// RV64I instruction field definitions
//   opcode classes seen by the execute stage
//   funct3 codes for ALU ops and branches
//   branch conditions and the decoded instruction struct
package rv_isa_pkg;

  typedef enum logic [1:0] {
    cls_reg    = 2'b00,
    cls_imm    = 2'b01,
    cls_branch = 2'b10
  } opclass_e;

  // OP / OP-IMM funct3
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // BRANCH funct3, 010 and 011 are reserved
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  typedef enum logic [2:0] {
    br_none,
    br_eq,
    br_ne,
    br_lt,
    br_ge,
    br_ltu,
    br_geu
  } branch_cond_e;

  // f7_alt is funct7 bit 5
  typedef struct packed {
    opclass_e   opclass;
    logic [2:0] funct3;
    logic       f7_alt;
  } exec_instr_t;

endpackage

// ==== source/sklansky_adder.sv ====
// Sklansky parallel-prefix adder
//   generate/propagate pairs per bit, carry in folded into bit 0
//   log2(width) prefix levels, sum and carry out
`timescale 1ns/1ps

module sklansky_adder #(
  parameter int width = 64
) (
  input  logic [width-1:0] a,
  input  logic [width-1:0] b,
  input  logic             c_in,
  output logic [width-1:0] sum,
  output logic             c_out
);

  localparam int levels = $clog2(width);

  // group generate / propagate per prefix level
  logic [width-1:0] g [0:levels];
  logic [width-1:0] p [0:levels];
  logic [width-1:0] prop;

  assign prop = a ^ b;

  // carry in enters as a generate at bit 0
  assign g[0] = (a & b) | {{(width-1){1'b0}}, prop[0] & c_in};
  assign p[0] = prop;

  genvar lv;
  genvar i;
  generate
    for (lv = 0; lv < levels; lv++) begin : g_level
      for (i = 0; i < width; i++) begin : g_bit
        if ((i & (1 << lv)) != 0) begin : g_node
          // last bit of the lower half of this block
          localparam int j = ((i >> lv) << lv) - 1;
          assign g[lv+1][i] = g[lv][i] | (p[lv][i] & g[lv][j]);
          assign p[lv+1][i] = p[lv][i] & p[lv][j];
        end else begin : g_pass
          assign g[lv+1][i] = g[lv][i];
          assign p[lv+1][i] = p[lv][i];
        end
      end
    end
  endgenerate

  // g[levels][k] is the carry out of bit k
  assign sum   = prop ^ {g[levels][width-2:0], c_in};
  assign c_out = g[levels][width-1];

endmodule

// ==== source/barrel_shifter.sv ====
// logarithmic barrel shifter
//   left shift via bit reversal around a right shifter
//   right shift fills with zero or the sign bit
`timescale 1ns/1ps

module barrel_shifter (
  input  logic [alu_pkg::xlen-1:0]    data,
  input  logic [alu_pkg::shamt_w-1:0] shamt,
  input  logic                        left,
  input  logic                        arithmetic,
  output logic [alu_pkg::xlen-1:0]    shifted
);

  import alu_pkg::*;

  logic [xlen-1:0] stage [0:shamt_w];
  logic            fill;

  function automatic logic [xlen-1:0] bit_reverse(input logic [xlen-1:0] v);
    logic [xlen-1:0] r;
    for (int k = 0; k < xlen; k++) begin
      r[k] = v[xlen-1-k];
    end
    return r;
  endfunction

  // sign fill only for a right arithmetic shift
  assign fill = arithmetic & ~left & data[xlen-1];

  assign stage[0] = left ? bit_reverse(data) : data;

  // stage s shifts by 2**s when shamt bit s is set
  genvar s;
  generate
    for (s = 0; s < shamt_w; s++) begin : g_stage
      localparam int amt = 1 << s;
      assign stage[s+1] = shamt[s] ? {{amt{fill}}, stage[s][xlen-1:amt]} : stage[s];
    end
  endgenerate

  // undo the reversal for left shifts
  assign shifted = left ? bit_reverse(stage[shamt_w]) : stage[shamt_w];

endmodule

// ==== source/alu.sv ====
// RV64I arithmetic-logic unit
//   add/sub through the prefix adder, shifts through the barrel shifter
//   slt/sltu from adder flags, bitwise xor/or/and
//   zero, negative, carry and overflow flags of the adder output
`timescale 1ns/1ps

module alu (
  input  logic [alu_pkg::xlen-1:0] a,
  input  logic [alu_pkg::xlen-1:0] b,
  input  alu_pkg::alu_op_e         op,
  output logic [alu_pkg::xlen-1:0] result,
  output alu_pkg::alu_flags_t      flags
);

  import alu_pkg::*;

  logic            sub;
  logic [xlen-1:0] b_eff;
  logic [xlen-1:0] sum;
  logic            c_out;
  logic [xlen-1:0] shifted;
  logic            slt_bit;
  logic            sltu_bit;

  // subtract for op_sub, op_slt and op_sltu
  assign sub   = ~op[2] & (op[3] | op[1]);
  assign b_eff = b ^ {xlen{sub}};

  sklansky_adder #(
    .width(xlen)
  ) u_adder (
    .a    (a),
    .b    (b_eff),
    .c_in (sub),
    .sum  (sum),
    .c_out(c_out)
  );

  barrel_shifter u_shifter (
    .data      (a),
    .shamt     (b[shamt_w-1:0]),
    .left      (op == op_sll),
    .arithmetic(op == op_sra),
    .shifted   (shifted)
  );

  assign flags.zero     = ~(|sum);
  assign flags.negative = sum[xlen-1];
  assign flags.carry    = c_out;
  // same-sign operands giving a different-sign sum
  assign flags.overflow = ~(a[xlen-1] ^ b_eff[xlen-1]) & (a[xlen-1] ^ sum[xlen-1]);

  assign slt_bit  = flags.negative ^ flags.overflow;
  // no carry out of a - b means a < b unsigned
  assign sltu_bit = ~c_out;

  always_comb begin
    case (op)
      op_add, op_sub:         result = sum;
      op_sll, op_srl, op_sra: result = shifted;
      op_slt:                 result = {{(xlen-1){1'b0}}, slt_bit};
      op_sltu:                result = {{(xlen-1){1'b0}}, sltu_bit};
      op_xor:                 result = a ^ b;
      op_or:                  result = a | b;
      op_and:                 result = a & b;
      default:                result = sum;
    endcase
  end

endmodule

// ==== source/alu_decoder.sv ====
// execute-stage decoder
//   funct3 / funct7[5] to ALU operation per opcode class
//   branch funct3 to branch condition, branches run a subtract
`timescale 1ns/1ps

module alu_decoder (
  input  rv_isa_pkg::exec_instr_t  instr,
  output alu_pkg::alu_op_e         alu_op,
  output rv_isa_pkg::branch_cond_e br_cond
);

  import alu_pkg::*;
  import rv_isa_pkg::*;

  always_comb begin
    alu_op  = op_add;
    br_cond = br_none;
    case (instr.opclass)
      cls_reg, cls_imm: begin
        case (instr.funct3)
          // immediate form has no subtract
          f3_add:  alu_op = (instr.opclass == cls_reg && instr.f7_alt) ? op_sub : op_add;
          f3_sll:  alu_op = op_sll;
          f3_slt:  alu_op = op_slt;
          f3_sltu: alu_op = op_sltu;
          f3_xor:  alu_op = op_xor;
          f3_sr:   alu_op = instr.f7_alt ? op_sra : op_srl;
          f3_or:   alu_op = op_or;
          f3_and:  alu_op = op_and;
          default: alu_op = op_add;
        endcase
      end
      cls_branch: begin
        case (instr.funct3)
          f3_beq:  br_cond = br_eq;
          f3_bne:  br_cond = br_ne;
          f3_blt:  br_cond = br_lt;
          f3_bge:  br_cond = br_ge;
          f3_bltu: br_cond = br_ltu;
          f3_bgeu: br_cond = br_geu;
          default: br_cond = br_none;
        endcase
        // reserved branch codes fall back to add
        alu_op = (br_cond != br_none) ? op_sub : op_add;
      end
      default: begin
        alu_op  = op_add;
        br_cond = br_none;
      end
    endcase
  end

endmodule

// ==== source/branch_resolver.sv ====
// branch resolver
//   taken decision from the flags of a - b
//   equality, signed and unsigned compares
`timescale 1ns/1ps

module branch_resolver (
  input  rv_isa_pkg::branch_cond_e cond,
  input  alu_pkg::alu_flags_t      flags,
  output logic                     taken
);

  import alu_pkg::*;
  import rv_isa_pkg::*;

  logic signed_lt;
  logic unsigned_lt;

  assign signed_lt   = flags.negative ^ flags.overflow;
  // borrow when there is no carry out
  assign unsigned_lt = ~flags.carry;

  always_comb begin
    case (cond)
      br_eq:   taken = flags.zero;
      br_ne:   taken = ~flags.zero;
      br_lt:   taken = signed_lt;
      br_ge:   taken = ~signed_lt;
      br_ltu:  taken = unsigned_lt;
      br_geu:  taken = ~unsigned_lt;
      default: taken = 1'b0;
    endcase
  end

endmodule

// ==== source/execute_stage.sv ====
// RV64I integer execute stage
//   decoder, ALU and branch resolver in one combinational path
//   output register with a one-cycle valid strobe
`timescale 1ns/1ps

module execute_stage (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     in_valid,
  input  rv_isa_pkg::exec_instr_t  instr,
  input  logic [alu_pkg::xlen-1:0] operand_a,
  input  logic [alu_pkg::xlen-1:0] operand_b,
  output logic                     out_valid,
  output alu_pkg::exec_result_t    out
);

  import alu_pkg::*;
  import rv_isa_pkg::*;

  alu_op_e         alu_op;
  branch_cond_e    br_cond;
  logic [xlen-1:0] result;
  alu_flags_t      flags;
  logic            taken;
  exec_result_t    next_out;

  alu_decoder u_decoder (
    .instr  (instr),
    .alu_op (alu_op),
    .br_cond(br_cond)
  );

  alu u_alu (
    .a     (operand_a),
    .b     (operand_b),
    .op    (alu_op),
    .result(result),
    .flags (flags)
  );

  branch_resolver u_resolver (
    .cond (br_cond),
    .flags(flags),
    .taken(taken)
  );

  assign next_out.result       = result;
  assign next_out.branch_taken = taken;

  // single pipeline register, no back-pressure
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      out       <= '0;
    end else begin
      out_valid <= in_valid;
      if (in_valid) begin
        out <= next_out;
      end
    end
  end

endmodule

// ==== verif/execute_stage_assert.sv ====
// bound checker for the execute stage
//   reference model of result, branch decision and adder flags
//   valid timing, reset state, result, branch taken and flag assertions
`timescale 1ns/1ps

module execute_stage_checker (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     in_valid,
  input rv_isa_pkg::exec_instr_t  instr,
  input logic [alu_pkg::xlen-1:0] operand_a,
  input logic [alu_pkg::xlen-1:0] operand_b,
  input alu_pkg::alu_flags_t      flags,
  input logic                     out_valid,
  input alu_pkg::exec_result_t    out
);

  import alu_pkg::*;
  import rv_isa_pkg::*;

  int unsigned  mismatch_count = 0;
  int unsigned  valid_error_count = 0;
  exec_result_t exp_q;

  // instructions whose adder runs a - b
  function automatic logic sub_form(input exec_instr_t i);
    if (i.opclass == cls_branch) begin
      return (i.funct3 != 3'b010) && (i.funct3 != 3'b011);
    end
    if (i.opclass == cls_reg || i.opclass == cls_imm) begin
      return (i.funct3 == f3_slt) || (i.funct3 == f3_sltu) ||
             (i.funct3 == f3_add && i.opclass == cls_reg && i.f7_alt);
    end
    return 1'b0;
  endfunction

  function automatic logic [xlen-1:0] ref_result(input exec_instr_t i,
                                                 input logic [xlen-1:0] a,
                                                 input logic [xlen-1:0] b);
    logic [shamt_w-1:0] sh;
    sh = b[shamt_w-1:0];
    if (i.opclass != cls_reg && i.opclass != cls_imm) begin
      return sub_form(i) ? a - b : a + b;
    end
    case (i.funct3)
      f3_sll:  return a << sh;
      f3_slt:  return {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
      f3_sltu: return {{(xlen-1){1'b0}}, a < b};
      f3_xor:  return a ^ b;
      f3_sr:   return i.f7_alt ? $unsigned($signed(a) >>> sh) : a >> sh;
      f3_or:   return a | b;
      f3_and:  return a & b;
      default: return sub_form(i) ? a - b : a + b;
    endcase
  endfunction

  function automatic logic ref_taken(input exec_instr_t i,
                                     input logic [xlen-1:0] a,
                                     input logic [xlen-1:0] b);
    if (i.opclass != cls_branch) begin
      return 1'b0;
    end
    case (i.funct3)
      f3_beq:  return a == b;
      f3_bne:  return a != b;
      f3_blt:  return $signed(a) < $signed(b);
      f3_bge:  return $signed(a) >= $signed(b);
      f3_bltu: return a < b;
      f3_bgeu: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic alu_flags_t ref_flags(input exec_instr_t i,
                                           input logic [xlen-1:0] a,
                                           input logic [xlen-1:0] b);
    alu_flags_t    f;
    logic [xlen:0] wide;
    logic [xlen-1:0] sum;
    if (sub_form(i)) begin
      sum        = a - b;
      f.carry    = a >= b;
      f.overflow = (a[xlen-1] != b[xlen-1]) && (sum[xlen-1] != a[xlen-1]);
    end else begin
      wide       = {1'b0, a} + {1'b0, b};
      sum        = wide[xlen-1:0];
      f.carry    = wide[xlen];
      f.overflow = (a[xlen-1] == b[xlen-1]) && (sum[xlen-1] != a[xlen-1]);
    end
    f.zero     = sum == '0;
    f.negative = sum[xlen-1];
    return f;
  endfunction

  // expected output one cycle behind the inputs
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      exp_q <= '0;
    end else if (in_valid) begin
      exp_q.result       <= ref_result(instr, operand_a, operand_b);
      exp_q.branch_taken <= ref_taken(instr, operand_a, operand_b);
    end
  end

  a_reset_clear: assert property (@(posedge clk) !rst_n |=> (!out_valid && out == '0))
    else begin
      valid_error_count++;
      $error("output register not cleared by reset at %0t", $time);
    end

  a_valid_follows: assert property (@(posedge clk) disable iff (!rst_n)
                                    in_valid |=> out_valid)
    else begin
      valid_error_count++;
      $error("out_valid missing one cycle after in_valid at %0t", $time);
    end

  a_no_spurious_valid: assert property (@(posedge clk) disable iff (!rst_n)
                                        !in_valid |=> !out_valid)
    else begin
      valid_error_count++;
      $error("out_valid raised without in_valid at %0t", $time);
    end

  a_result: assert property (@(posedge clk) disable iff (!rst_n)
                             out_valid |-> out.result == exp_q.result)
    else begin
      mismatch_count++;
      $error("MISMATCH %0t result %h expected %h", $time, out.result, exp_q.result);
    end

  a_taken: assert property (@(posedge clk) disable iff (!rst_n)
                            out_valid |-> out.branch_taken == exp_q.branch_taken)
    else begin
      mismatch_count++;
      $error("MISMATCH %0t branch_taken %b expected %b", $time, out.branch_taken,
             exp_q.branch_taken);
    end

  a_flags: assert property (@(posedge clk) disable iff (!rst_n)
                            in_valid |-> flags == ref_flags(instr, operand_a, operand_b))
    else begin
      mismatch_count++;
      $error("MISMATCH %0t flags %b", $time, flags);
    end

endmodule

bind execute_stage execute_stage_checker u_checker (
  .clk      (clk),
  .rst_n    (rst_n),
  .in_valid (in_valid),
  .instr    (instr),
  .operand_a(operand_a),
  .operand_b(operand_b),
  .flags    (flags),
  .out_valid(out_valid),
  .out      (out)
);

// ==== verif/tb_execute_stage.sv ====
// testbench for the execute stage
//   clock, synchronous reset, inputs driven on the falling edge
//   corner operands crossed with every opcode class, funct3 and f7_alt
//   reset applied again while an operation is presented
//   xorshift random stimulus with idle gaps
//   checking is done by the bound assertion module
`timescale 1ns/1ps

module tb_execute_stage;

  import alu_pkg::*;
  import rv_isa_pkg::*;

  logic            clk;
  logic            rst_n;
  logic            in_valid;
  exec_instr_t     instr;
  logic [xlen-1:0] operand_a;
  logic [xlen-1:0] operand_b;
  logic            out_valid;
  exec_result_t    out;

  logic [31:0]     rng_state;
  logic [xlen-1:0] corners [0:4];
  int unsigned     timeout_count;

  execute_stage u_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .instr    (instr),
    .operand_a(operand_a),
    .operand_b(operand_b),
    .out_valid(out_valid),
    .out      (out)
  );

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic draw32(output logic [31:0] v);
    rng_state = xorshift32(rng_state);
    v = rng_state;
  endtask

  task automatic draw64(output logic [xlen-1:0] v);
    logic [31:0] hi;
    logic [31:0] lo;
    draw32(hi);
    draw32(lo);
    v = {hi, lo};
  endtask

  // one operation, held until the next falling edge
  task automatic send_op(input opclass_e cls, input logic [2:0] f3, input logic alt,
                         input logic [xlen-1:0] a, input logic [xlen-1:0] b);
    @(negedge clk);
    in_valid      = 1'b1;
    instr.opclass = cls;
    instr.funct3  = f3;
    instr.f7_alt  = alt;
    operand_a     = a;
    operand_b     = b;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      in_valid = 1'b0;
    end
  endtask

  // reset for some cycles, inputs keep their values
  task automatic hold_reset(input int cycles);
    @(negedge clk);
    rst_n = 1'b0;
    repeat (cycles) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic wait_for_valid(input logic level, input int limit);
    int n;
    n = 0;
    while (out_valid !== level && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (out_valid !== level) begin
      timeout_count++;
      $display("timeout at %0t: out_valid did not reach %0b within %0d cycles",
               $time, level, limit);
    end
  endtask

  task automatic send_random_op();
    logic [31:0]     r;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    draw32(r);
    draw64(a);
    draw64(b);
    // bias toward equal pairs and corner operands
    if (r[9:8] == 2'b00) begin
      b = a;
    end else if (r[11:10] == 2'b00) begin
      a = corners[r[14:12] % 5];
    end
    if (r[17:16] == 2'b00) begin
      b = corners[r[20:18] % 5];
    end
    send_op(opclass_e'(r[1:0]), r[4:2], r[5], a, b);
  endtask

  initial begin
    int unsigned mismatches;
    int unsigned valid_errors;
    logic [31:0] gap;
    rst_n         = 1'b0;
    in_valid      = 1'b0;
    instr         = '0;
    operand_a     = '0;
    operand_b     = '0;
    rng_state     = 32'h89ca;
    timeout_count = 0;
    corners[0]    = '0;
    corners[1]    = '1;
    corners[2]    = {1'b1, {(xlen-1){1'b0}}};
    corners[3]    = {1'b0, {(xlen-1){1'b1}}};
    corners[4]    = 64'd1;

    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // quiet cycles before the first operation
    idle(3);
    send_op(cls_reg, f3_add, 1'b0, 64'd5, 64'd7);
    idle(1);
    wait_for_valid(1'b1, 4);
    wait_for_valid(1'b0, 4);

    // every corner pair, back to back
    for (int ia = 0; ia < 5; ia++) begin
      for (int ib = 0; ib < 5; ib++) begin
        for (int c = 0; c < 3; c++) begin
          for (int f = 0; f < 8; f++) begin
            for (int alt = 0; alt < 2; alt++) begin
              send_op(opclass_e'(c), 3'(f), alt[0], corners[ia], corners[ib]);
            end
          end
        end
      end
    end

    // output register holds a nonzero value when reset arrives
    send_op(cls_reg, f3_or, 1'b0, corners[2], corners[4]);
    hold_reset(3);

    for (int n = 0; n < 3000; n++) begin
      draw32(gap);
      if (gap[2:0] == 3'b000) begin
        idle(1);
      end else begin
        send_random_op();
      end
    end

    idle(2);
    wait_for_valid(1'b0, 4);

    mismatches   = u_dut.u_checker.mismatch_count;
    valid_errors = u_dut.u_checker.valid_error_count;
    $display("errors: %0d mismatches, %0d valid timing errors, %0d timeouts",
             mismatches, valid_errors, timeout_count);
    if (mismatches == 0 && valid_errors == 0 && timeout_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== src.f ====
source/alu_pkg.sv
source/rv_isa_pkg.sv
source/sklansky_adder.sv
source/barrel_shifter.sv
source/alu.sv
source/alu_decoder.sv
source/branch_resolver.sv
source/execute_stage.sv
verif/execute_stage_assert.sv
verif/tb_execute_stage.sv

// ==== Makefile ====
# Verilator flow for the execute stage

SIM := obj_dir/Vtb_execute_stage

.PHONY: all lint clean

all: $(SIM)
	./$(SIM) | tee sim.log
	@! grep -q "%Error" sim.log
	@grep -q "sim passed" sim.log

$(SIM): src.f $(wildcard source/*.sv) $(wildcard verif/*.sv)
	verilator --binary --timing --assert -f src.f --top-module tb_execute_stage

lint:
	verilator --lint-only -Wall --timing --assert -f src.f --top-module tb_execute_stage

clean:
	rm -rf obj_dir sim.log
